// File: design/key_entry.sv
/*
  key entry, turns note, length and octave buttons into the current tone
  choice; the last pressed note and length are held, octave is clamped
*/
`timescale 1ns/1ps

module key_entry (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [synth_pkg::NOTE_KEYS-1:0] note_key,
    input  logic [synth_pkg::LEN_KEYS-1:0]  length_key,
    input  logic                            oct_up,
    input  logic                            oct_down,
    output synth_pkg::tone_t                key_tone
);

    logic               up_q;
    logic               down_q;
    logic               up_edge;
    logic               down_edge;
    synth_pkg::note_t   note_sel;
    synth_pkg::len_t    len_sel;

    assign up_edge   = oct_up && !up_q;
    assign down_edge = oct_down && !down_q;

    // lowest set key wins, otherwise keep the previous choice
    always_comb begin
        note_sel = key_tone.note;
        len_sel  = key_tone.len;
        for (int i = synth_pkg::NOTE_KEYS - 1; i >= 0; i--) begin
            if (note_key[i])
                note_sel = synth_pkg::note_t'(i);
        end
        for (int j = synth_pkg::LEN_KEYS - 1; j >= 0; j--) begin
            if (length_key[j])
                len_sel = synth_pkg::len_t'(j);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_q            <= 1'b0;
            down_q          <= 1'b0;
            key_tone.octave <= synth_pkg::OCT_RESET;
            key_tone.note   <= synth_pkg::note_rest;
            key_tone.len    <= synth_pkg::len_quarter;
        end else begin
            up_q          <= oct_up;
            down_q        <= oct_down;
            key_tone.note <= note_sel;
            key_tone.len  <= len_sel;
            // both edges at once cancel out
            if (up_edge && !down_edge && key_tone.octave != synth_pkg::OCT_MAX)
                key_tone.octave <= key_tone.octave + 3'd1;
            else if (down_edge && !up_edge && key_tone.octave != 3'd0)
                key_tone.octave <= key_tone.octave - 3'd1;
        end
    end

    // octave moves one step at a time and never wraps past 0 or 7
    a_oct_step: assert property (@(posedge clk) disable iff (!rst_n)
        key_tone.octave != $past(key_tone.octave) |->
            (int'(key_tone.octave) - int'($past(key_tone.octave))) inside {1, -1});

endmodule

// File: design/note_recorder.sv
/*
  small tone memory for record and replay; synchronous write, read by
  address at all times; count holds the number of valid entries
*/
`timescale 1ns/1ps

module note_recorder #(
    parameter int DEPTH_BITS = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [DEPTH_BITS-1:0] wr_addr,
    input  synth_pkg::tone_t      wr_tone,
    input  logic [DEPTH_BITS-1:0] rd_addr,
    output synth_pkg::tone_t      rd_tone,
    output logic [DEPTH_BITS:0]   count
);

    synth_pkg::tone_t mem [2**DEPTH_BITS];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_tone;
    end

    assign rd_tone = mem[rd_addr];

    // highest written address plus one, so it saturates at the depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (wr_en && {1'b0, wr_addr} >= count) begin
            count <= {1'b0, wr_addr} + 1'b1;
        end
    end

endmodule

// File: design/song_rom.sv
/*
  built-in song table, combinational; gives the tone for a song number and
  step index plus the song's last index; song 0 is empty
*/
`timescale 1ns/1ps

module song_rom (
    input  logic [1:0]                          song,
    input  logic [synth_pkg::SONG_IDX_BITS-1:0] idx,
    output synth_pkg::tone_t                    song_tone,
    output logic [synth_pkg::SONG_IDX_BITS-1:0] last_idx
);

    function automatic synth_pkg::tone_t mk(input synth_pkg::octave_t o,
                                            input synth_pkg::note_t n,
                                            input synth_pkg::len_t l);
        mk = '{octave: o, note: n, len: l};
    endfunction

    always_comb begin
        // rest outside any song
        song_tone = mk(synth_pkg::OCT_RESET, synth_pkg::note_rest, synth_pkg::len_quarter);
        last_idx  = '0;
        case (song)
            2'd1: begin
                last_idx = 4'd6;
                case (idx)
                    4'd0: song_tone = mk(3'd4, synth_pkg::note_do, synth_pkg::len_quarter);
                    4'd1: song_tone = mk(3'd4, synth_pkg::note_do, synth_pkg::len_quarter);
                    4'd2: song_tone = mk(3'd4, synth_pkg::note_sol, synth_pkg::len_quarter);
                    4'd3: song_tone = mk(3'd4, synth_pkg::note_sol, synth_pkg::len_quarter);
                    4'd4: song_tone = mk(3'd4, synth_pkg::note_la, synth_pkg::len_quarter);
                    4'd5: song_tone = mk(3'd4, synth_pkg::note_la, synth_pkg::len_quarter);
                    4'd6: song_tone = mk(3'd4, synth_pkg::note_sol, synth_pkg::len_half);
                    default: ;
                endcase
            end
            2'd2: begin
                last_idx = 4'd6;
                case (idx)
                    4'd0: song_tone = mk(3'd4, synth_pkg::note_mi, synth_pkg::len_quarter);
                    4'd1: song_tone = mk(3'd4, synth_pkg::note_re, synth_pkg::len_quarter);
                    4'd2: song_tone = mk(3'd4, synth_pkg::note_do, synth_pkg::len_quarter);
                    4'd3: song_tone = mk(3'd4, synth_pkg::note_re, synth_pkg::len_quarter);
                    4'd4: song_tone = mk(3'd4, synth_pkg::note_mi, synth_pkg::len_quarter);
                    4'd5: song_tone = mk(3'd4, synth_pkg::note_rest, synth_pkg::len_quarter);
                    4'd6: song_tone = mk(3'd4, synth_pkg::note_mi, synth_pkg::len_half);
                    default: ;
                endcase
            end
            2'd3: begin
                last_idx = 4'd4;
                case (idx)
                    4'd0: song_tone = mk(3'd4, synth_pkg::note_do, synth_pkg::len_quarter);
                    4'd1: song_tone = mk(3'd4, synth_pkg::note_re, synth_pkg::len_quarter);
                    4'd2: song_tone = mk(3'd4, synth_pkg::note_mi, synth_pkg::len_half);
                    4'd3: song_tone = mk(3'd5, synth_pkg::note_fa, synth_pkg::len_half);
                    4'd4: song_tone = mk(3'd5, synth_pkg::note_sol, synth_pkg::len_whole);
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: design/steady_ctrl.sv
/*
  steady mode controller; detects hit edges, picks the mode and tone
  source, starts tones, steps the song and recorder indices and lights
  the goal note and length LEDs in song mode
*/
`timescale 1ns/1ps

module steady_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 en,
    input  logic                                 hit,
    input  logic                                 is_record,
    input  logic                                 is_rw,
    input  logic [1:0]                           song,
    input  synth_pkg::tone_t                     key_tone,
    input  logic                                 busy,
    input  synth_pkg::tone_t                     song_tone,
    input  logic [synth_pkg::SONG_IDX_BITS-1:0]  last_idx,
    input  synth_pkg::tone_t                     rd_tone,
    input  logic [synth_pkg::REC_DEPTH_BITS:0]   count,
    output logic                                 start,
    output synth_pkg::tone_t                     play_tone,
    output logic [synth_pkg::SONG_IDX_BITS-1:0]  song_idx,
    output logic                                 rec_wr_en,
    output logic [synth_pkg::REC_DEPTH_BITS-1:0] rec_addr,
    output logic [synth_pkg::NOTE_KEYS-1:0]      note_led,
    output logic [synth_pkg::LEN_KEYS-1:0]       length_led
);

    synth_pkg::mode_t mode;
    synth_pkg::mode_t mode_q;
    logic [1:0]       song_q;
    logic             hit_sync;
    logic             hit_prev;
    logic             play;
    logic             busy_q;
    logic             pending;
    logic             own_tone;
    logic             restart;
    logic             end_event;
    logic             auto_next;

    always_comb begin
        if (!en)
            mode = synth_pkg::mode_idle;
        else if (!is_record)
            mode = (song != 2'd0) ? synth_pkg::mode_song : synth_pkg::mode_free;
        else
            mode = is_rw ? synth_pkg::mode_rec_write : synth_pkg::mode_rec_read;
    end

    // new mode or new song restarts the sequence
    assign restart   = (mode != mode_q) || (song != song_q);
    assign auto_next = (mode == synth_pkg::mode_song) || (mode == synth_pkg::mode_rec_read);
    // busy falling on a tone this block auto-started
    assign end_event = own_tone && busy_q && !busy;

    always_comb begin
        case (mode_q)
            synth_pkg::mode_free,
            synth_pkg::mode_rec_write: start = play;
            synth_pkg::mode_song:      start = pending && !busy;
            synth_pkg::mode_rec_read:  start = pending && !busy && (count != '0);
            default:                   start = 1'b0;
        endcase
        // nothing starts while the mode or song is changing
        if (restart)
            start = 1'b0;
    end

    // only a start the tone generator accepts is recorded
    assign rec_wr_en = start && !busy && (mode_q == synth_pkg::mode_rec_write);

    always_comb begin
        case (mode_q)
            synth_pkg::mode_song:     play_tone = song_tone;
            synth_pkg::mode_rec_read: play_tone = rd_tone;
            default:                  play_tone = key_tone;
        endcase
    end

    // one-hot goal LEDs that stay dark outside song mode
    always_comb begin
        note_led   = '0;
        length_led = '0;
        if (mode_q == synth_pkg::mode_song) begin
            if (song_tone.note != synth_pkg::note_rest)
                note_led[song_tone.note] = 1'b1;
            length_led[song_tone.len] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_sync <= 1'b0;
            hit_prev <= 1'b0;
            play     <= 1'b0;
            busy_q   <= 1'b0;
            mode_q   <= synth_pkg::mode_idle;
            song_q   <= 2'd0;
            pending  <= 1'b0;
            own_tone <= 1'b0;
            song_idx <= '0;
            rec_addr <= '0;
        end else begin
            // sync flop then registered rising edge
            hit_sync <= hit;
            hit_prev <= hit_sync;
            play     <= hit_sync && !hit_prev;
            busy_q   <= busy;
            mode_q   <= mode;
            song_q   <= song;
            if (restart) begin
                song_idx <= '0;
                rec_addr <= '0;
                own_tone <= 1'b0;
                pending  <= auto_next;
            end else begin
                if (start) begin
                    pending  <= 1'b0;
                    own_tone <= (mode_q == synth_pkg::mode_song) ||
                                (mode_q == synth_pkg::mode_rec_read);
                end else if (end_event) begin
                    own_tone <= 1'b0;
                    pending  <= 1'b1;
                end
                // write address wraps at 8 on its own
                if (rec_wr_en)
                    rec_addr <= rec_addr + 1'b1;
                if (end_event && mode_q == synth_pkg::mode_song)
                    song_idx <= (song_idx == last_idx) ? '0 : song_idx + 1'b1;
                if (end_event && mode_q == synth_pkg::mode_rec_read)
                    rec_addr <= ({1'b0, rec_addr} == count - 1'b1) ? '0 : rec_addr + 1'b1;
            end
        end
    end

    // nothing starts or records once en drops
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !en |-> !start && !rec_wr_en);

    // a start while idle is taken by the tone generator
    a_start_taken: assert property (@(posedge clk) disable iff (!rst_n)
        start && !busy |=> busy);

endmodule

// File: design/synth_pkg.sv
/*
  shared types, constants and tone tables for the keyboard synthesizer core
  every block refers to these by scoped name
*/
package synth_pkg;

    localparam int NOTE_KEYS      = 7;
    localparam int LEN_KEYS       = 4;
    localparam int REC_DEPTH_BITS = 3;
    localparam int SONG_IDX_BITS  = 4;

    typedef logic [2:0] octave_t;

    // middle octave, used at reset and as the table base
    localparam octave_t OCT_RESET = 3'd4;
    localparam octave_t OCT_MAX   = 3'd7;

    typedef enum logic [2:0] {
        note_do, note_re, note_mi, note_fa, note_sol, note_la, note_ti, note_rest
    } note_t;

    typedef enum logic [1:0] {
        len_quarter, len_half, len_whole, len_double
    } len_t;

    typedef enum logic [2:0] {
        mode_idle, mode_free, mode_song, mode_rec_write, mode_rec_read
    } mode_t;

    // one tone, 8 bits
    typedef struct packed {
        octave_t octave;
        note_t   note;
        len_t    len;
    } tone_t;

    // half period in clock cycles, zero for a rest
    function automatic logic [15:0] half_period(input note_t n, input octave_t oct);
        logic [15:0] base;
        case (n)
            note_do:  base = 16'd15;
            note_re:  base = 16'd13;
            note_mi:  base = 16'd12;
            note_fa:  base = 16'd11;
            note_sol: base = 16'd10;
            note_la:  base = 16'd9;
            note_ti:  base = 16'd8;
            default:  base = 16'd0;
        endcase
        // higher octave halves, lower octave doubles
        if (oct >= OCT_RESET)
            half_period = base >> (oct - OCT_RESET);
        else
            half_period = base << (OCT_RESET - oct);
    endfunction

    // duration in ticks of TICKS_PER_UNIT
    function automatic logic [3:0] length_units(input len_t l);
        case (l)
            len_quarter: length_units = 4'd1;
            len_half:    length_units = 4'd2;
            len_whole:   length_units = 4'd4;
            default:     length_units = 4'd8;
        endcase
    endfunction

endpackage

// File: design/synth_top.sv
/*
  keyboard synthesizer core top level; wires key entry, controller, tone
  generator, song ROM and recorder; TICKS_PER_UNIT sets the quarter length
*/
`timescale 1ns/1ps

module synth_top #(
    parameter int TICKS_PER_UNIT = 64
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic                            hit,
    input  logic                            oct_up,
    input  logic                            oct_down,
    input  logic [synth_pkg::NOTE_KEYS-1:0] note_key,
    input  logic [synth_pkg::LEN_KEYS-1:0]  length_key,
    input  logic [1:0]                      song,
    input  logic                            is_record,
    input  logic                            is_rw,
    output logic [synth_pkg::NOTE_KEYS-1:0] note_led,
    output logic [synth_pkg::LEN_KEYS-1:0]  length_led,
    output logic                            busy,
    output logic                            buzzer
);

    synth_pkg::tone_t                     key_tone;
    synth_pkg::tone_t                     play_tone;
    synth_pkg::tone_t                     song_tone;
    synth_pkg::tone_t                     rd_tone;
    logic [synth_pkg::SONG_IDX_BITS-1:0]  song_idx;
    logic [synth_pkg::SONG_IDX_BITS-1:0]  last_idx;
    logic [synth_pkg::REC_DEPTH_BITS-1:0] rec_addr;
    logic [synth_pkg::REC_DEPTH_BITS:0]   count;
    logic                                 start;
    logic                                 rec_wr_en;

    key_entry u_key_entry (
        .clk(clk), .rst_n(rst_n), .note_key(note_key), .length_key(length_key),
        .oct_up(oct_up), .oct_down(oct_down), .key_tone(key_tone)
    );

    steady_ctrl u_steady_ctrl (
        .clk(clk), .rst_n(rst_n), .en(en), .hit(hit), .is_record(is_record),
        .is_rw(is_rw), .song(song), .key_tone(key_tone), .busy(busy),
        .song_tone(song_tone), .last_idx(last_idx), .rd_tone(rd_tone), .count(count),
        .start(start), .play_tone(play_tone), .song_idx(song_idx),
        .rec_wr_en(rec_wr_en), .rec_addr(rec_addr),
        .note_led(note_led), .length_led(length_led)
    );

    tone_gen #(.TICKS_PER_UNIT(TICKS_PER_UNIT)) u_tone_gen (
        .clk(clk), .rst_n(rst_n), .start(start), .play_tone(play_tone),
        .busy(busy), .buzzer(buzzer)
    );

    song_rom u_song_rom (
        .song(song), .idx(song_idx), .song_tone(song_tone), .last_idx(last_idx)
    );

    // one address serves both record and replay
    note_recorder #(.DEPTH_BITS(synth_pkg::REC_DEPTH_BITS)) u_note_recorder (
        .clk(clk), .rst_n(rst_n), .wr_en(rec_wr_en), .wr_addr(rec_addr),
        .wr_tone(play_tone), .rd_addr(rec_addr), .rd_tone(rd_tone), .count(count)
    );

endmodule

// File: design/tone_gen.sv
/*
  square wave tone generator; a start strobe while idle latches the tone,
  then busy is held for the tone length and the buzzer toggles at the
  note's half period; starts while busy are dropped
*/
`timescale 1ns/1ps

module tone_gen #(
    parameter int TICKS_PER_UNIT = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  synth_pkg::tone_t play_tone,
    output logic             busy,
    output logic             buzzer
);

    localparam int DUR_BITS = $clog2(8 * TICKS_PER_UNIT);

    synth_pkg::tone_t    cur_tone;
    logic [DUR_BITS-1:0] dur_cnt;
    logic [DUR_BITS-1:0] dur_load;
    logic [15:0]         hp;
    logic [15:0]         hp_cnt;
    logic                hp_done;

    // cycles minus one, so busy lasts exactly units * ticks
    assign dur_load = DUR_BITS'(synth_pkg::length_units(play_tone.len) * TICKS_PER_UNIT - 1);

    assign hp      = synth_pkg::half_period(cur_tone.note, cur_tone.octave);
    // rest has hp of zero and never toggles
    assign hp_done = (hp != 16'd0) && (hp_cnt == hp - 16'd1);

    // latched tone, only read while busy
    always_ff @(posedge clk) begin
        if (start && !busy)
            cur_tone <= play_tone;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            buzzer  <= 1'b0;
            dur_cnt <= '0;
            hp_cnt  <= '0;
        end else if (!busy) begin
            buzzer <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                dur_cnt <= dur_load;
                hp_cnt  <= '0;
            end
        end else if (dur_cnt == '0) begin
            // end of tone
            busy   <= 1'b0;
            buzzer <= 1'b0;
        end else begin
            dur_cnt <= dur_cnt - 1'b1;
            if (hp_done) begin
                buzzer <= !buzzer;
                hp_cnt <= '0;
            end else begin
                hp_cnt <= hp_cnt + 16'd1;
            end
        end
    end

    a_quiet_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !buzzer);

    // a start mid tone neither restarts nor stretches it
    a_start_dropped: assert property (@(posedge clk) disable iff (!rst_n)
        busy && start && dur_cnt != '0 |=>
            busy && dur_cnt == $past(dur_cnt) - 1'b1 && cur_tone == $past(cur_tone));

endmodule

// File: verification/tb_synth.sv
/*
  testbench for the synthesizer core; tasks play tones in free, octave,
  song and record modes, concurrent assertions measure busy length, buzzer
  half period and LEDs against the expected tone latched at each start
*/
`timescale 1ns/1ps

module tb_synth;

    localparam int TICKS = 64;
    // longest test sequence is well under 20k cycles, so this is a safe cap
    localparam int TIMEOUT_CYCLES = 60000;

    logic clk;
    logic rst_n;
    logic en;
    logic hit;
    logic oct_up;
    logic oct_down;
    logic [6:0] note_key;
    logic [3:0] length_key;
    logic [1:0] song;
    logic is_record;
    logic is_rw;
    logic [6:0] note_led;
    logic [3:0] length_led;
    logic busy;
    logic buzzer;

    synth_pkg::tone_t exp_tone;
    synth_pkg::tone_t cur_tone;
    synth_pkg::tone_t rec_q[$];
    logic [31:0] rng;
    logic idle_chk;
    logic song_chk;
    logic buzz_prev;
    int busy_len;
    int seg_len;
    int errors;
    int tests_run;
    int tests_failed;
    int cycle_count;

    synth_top #(.TICKS_PER_UNIT(TICKS)) u_synth_top (
        .clk(clk), .rst_n(rst_n), .en(en), .hit(hit), .oct_up(oct_up),
        .oct_down(oct_down), .note_key(note_key), .length_key(length_key),
        .song(song), .is_record(is_record), .is_rw(is_rw), .note_led(note_led),
        .length_led(length_led), .busy(busy), .buzzer(buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // octave 4 base, halved per octave up, doubled per octave down
    function automatic int expected_half(input synth_pkg::tone_t t);
        int base;
        base = synth_pkg::half_period(t.note, 3'd4);
        if (t.octave >= 3'd4)
            expected_half = base >> (t.octave - 3'd4);
        else
            expected_half = base << (3'd4 - t.octave);
    endfunction

    // 1, 2, 4 or 8 units
    function automatic int expected_cycles(input synth_pkg::tone_t t);
        expected_cycles = (1 << t.len) * TICKS;
    endfunction

    function automatic logic [6:0] goal_note_led(input synth_pkg::tone_t t);
        if (t.note == synth_pkg::note_rest)
            goal_note_led = '0;
        else
            goal_note_led = 7'd1 << t.note;
    endfunction

    // song 1, seven steps at octave 4
    function automatic synth_pkg::tone_t song1_step(input int idx);
        synth_pkg::note_t n;
        case (idx)
            0, 1:    n = synth_pkg::note_do;
            4, 5:    n = synth_pkg::note_la;
            default: n = synth_pkg::note_sol;
        endcase
        song1_step = '{octave: 3'd4, note: n,
                       len: (idx == 6) ? synth_pkg::len_half : synth_pkg::len_quarter};
    endfunction

    // tone length and buzzer segment counters, expected tone latched at start
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_len  <= 0;
            seg_len   <= 0;
            buzz_prev <= 1'b0;
            cur_tone  <= '0;
        end else begin
            buzz_prev <= buzzer;
            if (!busy) begin
                busy_len <= 0;
                seg_len  <= 0;
            end else begin
                busy_len <= busy_len + 1;
                if (busy_len == 0)
                    cur_tone <= exp_tone;
                if (seg_len != 0 && buzzer != buzz_prev)
                    seg_len <= 1;
                else
                    seg_len <= seg_len + 1;
            end
        end
    end

    a_duration: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> busy_len == expected_cycles(cur_tone))
        else begin
            errors++;
            $display("mismatch busy length: got %h expected %h", $sampled(busy_len),
                     expected_cycles($sampled(cur_tone)));
        end

    // only whole segments, the last one may be cut by the end of tone
    a_half_period: assert property (@(posedge clk) disable iff (!rst_n)
        busy && seg_len != 0 && buzzer != buzz_prev |-> seg_len == expected_half(cur_tone))
        else begin
            errors++;
            $display("mismatch buzzer half period: got %h expected %h", $sampled(seg_len),
                     expected_half($sampled(cur_tone)));
        end

    a_rest_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        busy && busy_len != 0 && expected_half(cur_tone) == 0 |-> !buzzer)
        else begin
            errors++;
            $display("mismatch buzzer during rest: got %h expected 0", $sampled(buzzer));
        end

    a_note_led: assert property (@(posedge clk) disable iff (!rst_n)
        song_chk && busy && busy_len != 0 |-> note_led == goal_note_led(cur_tone))
        else begin
            errors++;
            $display("mismatch note_led: got %h expected %h", $sampled(note_led),
                     goal_note_led($sampled(cur_tone)));
        end

    a_length_led: assert property (@(posedge clk) disable iff (!rst_n)
        song_chk && busy && busy_len != 0 |-> length_led == 4'd1 << cur_tone.len)
        else begin
            errors++;
            $display("mismatch length_led: got %h expected %h", $sampled(length_led),
                     4'd1 << $sampled(cur_tone.len));
        end

    a_idle_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        idle_chk |-> !busy && !buzzer && note_led == '0 && length_led == '0)
        else begin
            errors++;
            $display("mismatch idle outputs: busy %h buzzer %h note_led %h length_led %h",
                     $sampled(busy), $sampled(buzzer), $sampled(note_led),
                     $sampled(length_led));
        end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic set_mode(input logic m_en, input logic rec, input logic rw,
                            input logic [1:0] s);
        en        = m_en;
        is_record = rec;
        is_rw     = rw;
        song      = s;
    endtask

    // one cycle press, key entry holds the choice afterwards
    task automatic press_keys(input int n, input int l);
        note_key     = 7'd1 << n;
        length_key   = 4'd1 << l;
        exp_tone.note = synth_pkg::note_t'(n);
        exp_tone.len  = synth_pkg::len_t'(l);
        next_cycle();
        note_key   = '0;
        length_key = '0;
    endtask

    task automatic hit_once();
        hit = 1'b1;
        next_cycle();
        next_cycle();
        hit = 1'b0;
        next_cycle();
    endtask

    // reference octave, clamped at 0 and 7
    task automatic step_octave(input logic up);
        oct_up   = up;
        oct_down = !up;
        next_cycle();
        oct_up   = 1'b0;
        oct_down = 1'b0;
        next_cycle();
        if (up && exp_tone.octave != 3'd7)
            exp_tone.octave = exp_tone.octave + 3'd1;
        else if (!up && exp_tone.octave != 3'd0)
            exp_tone.octave = exp_tone.octave - 3'd1;
    endtask

    task automatic wait_tone_start();
        int n;
        n = 0;
        while (!busy && n < 16) begin
            next_cycle();
            n++;
        end
        if (!busy) begin
            errors++;
            $display("no tone started within 16 cycles");
        end
    endtask

    task automatic wait_tone_end();
        int n;
        n = 0;
        while (busy && n < 8 * TICKS + 16) begin
            next_cycle();
            n++;
        end
        if (busy) begin
            errors++;
            $display("tone did not end within %0d cycles", 8 * TICKS + 16);
        end
    endtask

    // extra hit lands mid tone and must be dropped
    task automatic play_key_tone(input logic extra_hit);
        hit_once();
        wait_tone_start();
        if (extra_hit) begin
            repeat (100) next_cycle();
            hit_once();
        end
        wait_tone_end();
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, errors - mark);
        end
    endtask

    initial begin
        int mark;
        rst_n        = 1'b0;
        en           = 1'b0;
        hit          = 1'b0;
        oct_up       = 1'b0;
        oct_down     = 1'b0;
        note_key     = '0;
        length_key   = '0;
        song         = 2'd0;
        is_record    = 1'b0;
        is_rw        = 1'b0;
        idle_chk     = 1'b0;
        song_chk     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rng          = 32'hded2;
        exp_tone     = '{octave: 3'd4, note: synth_pkg::note_rest, len: synth_pkg::len_quarter};
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        mark = errors;
        idle_chk = 1'b1;
        repeat (8) next_cycle();
        idle_chk = 1'b0;
        report_test("reset", mark);

        // first tone is the reset choice, a quarter rest
        mark = errors;
        set_mode(1'b1, 1'b0, 1'b0, 2'd0);
        play_key_tone(1'b0);
        for (int l = 0; l < 4; l++) begin
            for (int k = 0; k < 6; k++) begin
                rng = xorshift(rng);
                press_keys(int'(rng % 7), l);
                play_key_tone(1'b0);
            end
        end
        report_test("free_play", mark);

        // up past 7, down past 0, then back to 4
        mark = errors;
        press_keys(0, 3);
        play_key_tone(1'b0);
        for (int k = 0; k < 4; k++) begin
            step_octave(1'b1);
            play_key_tone(k == 1);
        end
        for (int k = 0; k < 8; k++) begin
            step_octave(1'b0);
            play_key_tone(1'b0);
        end
        for (int k = 0; k < 4; k++)
            step_octave(1'b1);
        report_test("octave", mark);

        // nine steps so the wrap after the last index is seen
        mark = errors;
        exp_tone = song1_step(0);
        set_mode(1'b1, 1'b0, 1'b0, 2'd1);
        song_chk = 1'b1;
        for (int s = 0; s < 9; s++) begin
            exp_tone = song1_step(s % 7);
            wait_tone_start();
            wait_tone_end();
        end
        set_mode(1'b0, 1'b0, 1'b0, 2'd0);
        song_chk = 1'b0;
        report_test("song", mark);

        mark = errors;
        set_mode(1'b1, 1'b1, 1'b1, 2'd0);
        for (int k = 0; k < 4; k++) begin
            rng = xorshift(rng);
            press_keys(int'(rng % 7), int'((rng >> 8) % 4));
            play_key_tone(1'b0);
            rec_q.push_back(exp_tone);
        end
        exp_tone = rec_q[0];
        set_mode(1'b1, 1'b1, 1'b0, 2'd0);
        for (int k = 0; k < 5; k++) begin
            exp_tone = rec_q[k % 4];
            wait_tone_start();
            wait_tone_end();
        end
        set_mode(1'b0, 1'b0, 1'b0, 2'd0);
        report_test("record_replay", mark);

        repeat (4) next_cycle();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: vlog.f
design/synth_pkg.sv
design/key_entry.sv
design/tone_gen.sv
design/song_rom.sv
design/note_recorder.sv
design/steady_ctrl.sv
design/synth_top.sv
verification/tb_synth.sv
